// File: Bender.yml
package:
  name: pong

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pong_pkg.sv
      - hdl/rect_raster.sv
      - hdl/paddle_motion.sv
      - hdl/ball_motion.sv
      - hdl/draw_sequencer.sv
      - hdl/pixel_mux.sv
      - hdl/pong_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - testbench/pong_tb.sv

// File: hdl/ball_motion.sv
`timescale 1ns/1ps

`include "pong_defines.svh"

module ball_motion import pong_pkg::*; (
	input  logic   clock,
	input  logic   reset_n,
	input  logic   update,
	input  logic   respawn,
	input  logic   respawn_right,
	input  coord_t p1_y,
	input  coord_t p2_y,
	output coord_t ball_x,
	output coord_t ball_y,
	output logic   left_goal,
	output logic   right_goal
);

	localparam coord_t P1_LEFT = coord_t'(`P1_X);
	localparam coord_t P1_RIGHT = coord_t'(`P1_X + `PADDLE_W);
	localparam coord_t P2_LEFT = coord_t'(`P2_X);
	localparam coord_t P2_RIGHT = coord_t'(`P2_X + `PADDLE_W);

	logic   dir_right;
	logic   dir_up;
	logic   next_right;
	logic   next_up;
	logic   p1_span;
	logic   p2_span;
	logic   in_goal;
	coord_t ball_edge;

	assign ball_edge = ball_x + coord_t'(`BALL_SIZE);
	assign p1_span = (p1_y <= ball_y) && (ball_y <= p1_y + coord_t'(`PADDLE_H));
	assign p2_span = (p2_y <= ball_y) && (ball_y <= p2_y + coord_t'(`PADDLE_H));
	assign in_goal = (ball_y >= coord_t'(`GOAL_Y_LO)) && (ball_y <= coord_t'(`GOAL_Y_HI));

	// bounce decision from the old position
	always_comb begin
		next_right = dir_right;
		next_up = dir_up;
		if (ball_x == coord_t'(`WALL_LEFT))
			next_right = 1'b1;
		else if (ball_x == coord_t'(`WALL_RIGHT))
			next_right = 1'b0;
		if (ball_y == coord_t'(`WALL_TOP))
			next_up = 1'b0;
		else if (ball_y == coord_t'(`WALL_BOTTOM))
			next_up = 1'b1;
		// paddles override walls
		if (p1_span) begin
			if (ball_edge == P1_LEFT)
				next_right = 1'b0;
			else if (ball_x == P1_RIGHT)
				next_right = 1'b1;
		end
		if (p2_span) begin
			if (ball_edge == P2_LEFT)
				next_right = 1'b0;
			else if (ball_x == P2_RIGHT)
				next_right = 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset_n) begin
			ball_x <= coord_t'(`BALL_X0);
			ball_y <= coord_t'(`BALL_Y0);
			dir_right <= 1'b1;
			dir_up <= 1'b1;
			left_goal <= 1'b0;
			right_goal <= 1'b0;
		end else begin
			left_goal <= 1'b0;
			right_goal <= 1'b0;
			if (respawn) begin
				ball_x <= respawn_right ? coord_t'(`SPAWN_RIGHT_X) : coord_t'(`SPAWN_LEFT_X);
				ball_y <= coord_t'(`SPAWN_Y);
				dir_right <= 1'b1;
				dir_up <= 1'b1;
			end else if (update) begin
				left_goal <= (ball_x == coord_t'(`WALL_LEFT)) && in_goal;
				right_goal <= (ball_edge == coord_t'(`RIGHT_GOAL_EDGE)) && in_goal;
				// step with the old direction
				ball_x <= dir_right ? ball_x + 1'b1 : ball_x - 1'b1;
				ball_y <= dir_up ? ball_y - 1'b1 : ball_y + 1'b1;
				dir_right <= next_right;
				dir_up <= next_up;
			end
		end
	end

endmodule

// File: hdl/draw_sequencer.sv
`timescale 1ns/1ps

`include "pong_defines.svh"

module draw_sequencer import pong_pkg::*; (
	input  logic    clock,
	input  logic    reset_n,
	input  logic    go,
	input  logic    p1_done,
	input  logic    p2_done,
	input  logic    ball_done,
	input  logic    left_goal,
	input  logic    right_goal,
	output logic    p1_draw,
	output logic    p2_draw,
	output logic    ball_draw,
	output colour_t pass_colour,
	output logic    update,
	output logic    respawn,
	output logic    respawn_right,
	output score_t  p1_score,
	output score_t  p2_score
);

	localparam int CNT_W = $clog2(`FRAME_TICKS + 1);
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`FRAME_TICKS - 1);

	seq_state_t       state;
	seq_state_t       next_state;
	logic [CNT_W-1:0] frame_cnt;

	always_comb begin
		next_state = state;
		case (state)
			st_idle:       if (go) next_state = st_draw_p1;
			st_draw_p1:    if (p1_done) next_state = st_draw_p2;
			st_draw_p2:    if (p2_done) next_state = st_draw_ball;
			st_draw_ball:  if (ball_done) next_state = st_wait_frame;
			st_wait_frame: if (frame_cnt == CNT_LAST) next_state = st_erase_p1;
			st_erase_p1:   if (p1_done) next_state = st_erase_p2;
			st_erase_p2:   if (p2_done) next_state = st_erase_ball;
			st_erase_ball: if (ball_done) next_state = st_update;
			st_update:     next_state = st_settle;
			// goal pulses land here
			st_settle:     next_state = (left_goal || right_goal) ? st_respawn : st_draw_p1;
			st_respawn:    next_state = st_draw_p1;
			default:       next_state = st_idle;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset_n)
			state <= st_idle;
		else
			state <= next_state;
	end

	// frame delay
	always_ff @(posedge clock) begin
		if (reset_n || state != st_wait_frame)
			frame_cnt <= '0;
		else
			frame_cnt <= frame_cnt + 1'b1;
	end

	// a left goal scores for player 2 and serves from the right
	always_ff @(posedge clock) begin
		if (reset_n) begin
			p1_score <= '0;
			p2_score <= '0;
			respawn_right <= 1'b0;
		end else if (state == st_settle) begin
			if (left_goal) begin
				p2_score <= p2_score + 1'b1;
				respawn_right <= 1'b1;
			end else if (right_goal) begin
				p1_score <= p1_score + 1'b1;
				respawn_right <= 1'b0;
			end
		end
	end

	assign p1_draw = (state == st_draw_p1) || (state == st_erase_p1);
	assign p2_draw = (state == st_draw_p2) || (state == st_erase_p2);
	assign ball_draw = (state == st_draw_ball) || (state == st_erase_ball);
	assign update = (state == st_update);
	assign respawn = (state == st_respawn);

	always_comb begin
		case (state)
			st_draw_p1:   pass_colour = colour_t'(`COLOUR_P1);
			st_draw_p2:   pass_colour = colour_t'(`COLOUR_P2);
			st_draw_ball: pass_colour = colour_t'(`COLOUR_BALL);
			default:      pass_colour = colour_t'(`COLOUR_BLACK);
		endcase
	end

endmodule

// File: hdl/paddle_motion.sv
`timescale 1ns/1ps

`include "pong_defines.svh"

module paddle_motion import pong_pkg::*; #(
	parameter int Y_START = `PADDLE_Y0
) (
	input  logic   clock,
	input  logic   reset_n,
	input  logic   update,
	input  logic   up,
	input  logic   down,
	output coord_t y_top
);

	localparam coord_t Y_MIN = coord_t'(`PADDLE_Y_MIN);
	localparam coord_t Y_MAX = coord_t'(`PADDLE_Y_MAX);

	always_ff @(posedge clock) begin
		if (reset_n) begin
			y_top <= coord_t'(Y_START);
		end else if (update) begin
			// a legal down move beats up
			if (down && y_top <= Y_MAX)
				y_top <= y_top + 1'b1;
			else if (up && y_top >= Y_MIN)
				y_top <= y_top - 1'b1;
		end
	end

endmodule

// File: hdl/pixel_mux.sv
`timescale 1ns/1ps

module pixel_mux import pong_pkg::*; (
	input  logic    clock,
	input  logic    reset_n,
	input  logic    p1_draw,
	input  logic    p2_draw,
	input  logic    ball_draw,
	input  coord_t  p1_x,
	input  coord_t  p1_y,
	input  coord_t  p2_x,
	input  coord_t  p2_y,
	input  coord_t  ball_x,
	input  coord_t  ball_y,
	input  colour_t pass_colour,
	output logic    write_en,
	output coord_t  x,
	output coord_t  y,
	output colour_t colour
);

	always_ff @(posedge clock) begin
		if (reset_n)
			write_en <= 1'b0;
		else
			write_en <= p1_draw || p2_draw || ball_draw;
	end

	// only one enable is high at a time
	always_ff @(posedge clock) begin
		if (p1_draw) begin
			x <= p1_x;
			y <= p1_y;
		end else if (p2_draw) begin
			x <= p2_x;
			y <= p2_y;
		end else if (ball_draw) begin
			x <= ball_x;
			y <= ball_y;
		end
		colour <= pass_colour;
	end

endmodule

// File: hdl/pong_defines.svh
`ifndef PONG_DEFINES_SVH
`define PONG_DEFINES_SVH

// object sizes in pixels
`define PADDLE_W 4
`define PADDLE_H 20
`define BALL_SIZE 10

// paddle columns and start row
`define P1_X 30
`define P2_X 290
`define PADDLE_Y0 100
`define PADDLE_Y_MIN 6
`define PADDLE_Y_MAX 214

// walls against the ball's top-left corner
`define WALL_LEFT 6
`define WALL_RIGHT 302
`define WALL_TOP 6
`define WALL_BOTTOM 220

// goal window
`define GOAL_Y_LO 90
`define GOAL_Y_HI 150
`define RIGHT_GOAL_EDGE 306

// ball start and respawn points
`define BALL_X0 160
`define BALL_Y0 120
`define SPAWN_LEFT_X 44
`define SPAWN_RIGHT_X 264
`define SPAWN_Y 110

`define COLOUR_P1 5
`define COLOUR_P2 2
`define COLOUR_BALL 4
`define COLOUR_BLACK 0

// cycles between the draw and erase passes
`define FRAME_TICKS 64

`endif

// File: hdl/pong_pkg.sv
package pong_pkg;

	// screen coordinate
	typedef logic [10:0] coord_t;

	// 3-bit rgb pixel
	typedef logic [2:0] colour_t;

	// wraps at 16
	typedef logic [3:0] score_t;

	typedef enum logic [3:0] {
		st_idle,
		st_draw_p1,
		st_draw_p2,
		st_draw_ball,
		st_wait_frame,
		st_erase_p1,
		st_erase_p2,
		st_erase_ball,
		st_update,
		st_settle,
		st_respawn
	} seq_state_t;

endpackage

// File: hdl/pong_top.sv
`timescale 1ns/1ps

`include "pong_defines.svh"

module pong_top import pong_pkg::*; (
	input  logic    clock,
	input  logic    reset_n,
	input  logic    go,
	input  logic    p1_up,
	input  logic    p1_down,
	input  logic    p2_up,
	input  logic    p2_down,
	output logic    write_en,
	output coord_t  x,
	output coord_t  y,
	output colour_t colour,
	output score_t  p1_score,
	output score_t  p2_score
);

	logic    p1_draw, p2_draw, ball_draw;
	logic    p1_done, p2_done, ball_done;
	logic    update, respawn, respawn_right;
	logic    left_goal, right_goal;
	colour_t pass_colour;
	coord_t  p1_y_top, p2_y_top;
	coord_t  ball_x, ball_y;
	coord_t  p1_pix_x, p1_pix_y;
	coord_t  p2_pix_x, p2_pix_y;
	coord_t  ball_pix_x, ball_pix_y;

	draw_sequencer u_seq (
		.clock(clock), .reset_n(reset_n), .go(go),
		.p1_done(p1_done), .p2_done(p2_done), .ball_done(ball_done),
		.left_goal(left_goal), .right_goal(right_goal),
		.p1_draw(p1_draw), .p2_draw(p2_draw), .ball_draw(ball_draw),
		.pass_colour(pass_colour), .update(update),
		.respawn(respawn), .respawn_right(respawn_right),
		.p1_score(p1_score), .p2_score(p2_score)
	);

	paddle_motion #(.Y_START(`PADDLE_Y0)) u_p1_motion (
		.clock(clock), .reset_n(reset_n), .update(update),
		.up(p1_up), .down(p1_down), .y_top(p1_y_top)
	);

	paddle_motion #(.Y_START(`PADDLE_Y0)) u_p2_motion (
		.clock(clock), .reset_n(reset_n), .update(update),
		.up(p2_up), .down(p2_down), .y_top(p2_y_top)
	);

	ball_motion u_ball_motion (
		.clock(clock), .reset_n(reset_n), .update(update),
		.respawn(respawn), .respawn_right(respawn_right),
		.p1_y(p1_y_top), .p2_y(p2_y_top),
		.ball_x(ball_x), .ball_y(ball_y),
		.left_goal(left_goal), .right_goal(right_goal)
	);

	rect_raster #(.WIDTH(`PADDLE_W), .HEIGHT(`PADDLE_H)) u_p1_raster (
		.clock(clock), .reset_n(reset_n), .enable(p1_draw),
		.x_org(coord_t'(`P1_X)), .y_org(p1_y_top),
		.x_out(p1_pix_x), .y_out(p1_pix_y), .rect_done(p1_done)
	);

	rect_raster #(.WIDTH(`PADDLE_W), .HEIGHT(`PADDLE_H)) u_p2_raster (
		.clock(clock), .reset_n(reset_n), .enable(p2_draw),
		.x_org(coord_t'(`P2_X)), .y_org(p2_y_top),
		.x_out(p2_pix_x), .y_out(p2_pix_y), .rect_done(p2_done)
	);

	rect_raster #(.WIDTH(`BALL_SIZE), .HEIGHT(`BALL_SIZE)) u_ball_raster (
		.clock(clock), .reset_n(reset_n), .enable(ball_draw),
		.x_org(ball_x), .y_org(ball_y),
		.x_out(ball_pix_x), .y_out(ball_pix_y), .rect_done(ball_done)
	);

	pixel_mux u_mux (
		.clock(clock), .reset_n(reset_n),
		.p1_draw(p1_draw), .p2_draw(p2_draw), .ball_draw(ball_draw),
		.p1_x(p1_pix_x), .p1_y(p1_pix_y),
		.p2_x(p2_pix_x), .p2_y(p2_pix_y),
		.ball_x(ball_pix_x), .ball_y(ball_pix_y),
		.pass_colour(pass_colour),
		.write_en(write_en), .x(x), .y(y), .colour(colour)
	);

endmodule

// File: hdl/rect_raster.sv
`timescale 1ns/1ps

module rect_raster import pong_pkg::*; #(
	parameter int WIDTH = 4,
	parameter int HEIGHT = 20
) (
	input  logic   clock,
	input  logic   reset_n,
	input  logic   enable,
	input  coord_t x_org,
	input  coord_t y_org,
	output coord_t x_out,
	output coord_t y_out,
	output logic   rect_done
);

	localparam coord_t X_LAST = coord_t'(WIDTH - 1);
	localparam coord_t Y_LAST = coord_t'(HEIGHT - 1);

	coord_t x_cnt;
	coord_t y_cnt;

	// row by row with x fastest
	always_ff @(posedge clock) begin
		if (reset_n) begin
			x_cnt <= '0;
			y_cnt <= '0;
		end else if (enable) begin
			if (x_cnt == X_LAST) begin
				x_cnt <= '0;
				if (y_cnt == Y_LAST)
					y_cnt <= '0;
				else
					y_cnt <= y_cnt + 1'b1;
			end else begin
				x_cnt <= x_cnt + 1'b1;
			end
		end
	end

	assign rect_done = enable && (x_cnt == X_LAST) && (y_cnt == Y_LAST);
	assign x_out = x_org + x_cnt;
	assign y_out = y_org + y_cnt;

endmodule

// File: pong_top.f
+incdir+hdl
hdl/pong_pkg.sv
hdl/rect_raster.sv
hdl/paddle_motion.sv
hdl/ball_motion.sv
hdl/draw_sequencer.sv
hdl/pixel_mux.sv
hdl/pong_top.sv
testbench/pong_tb.sv

// File: testbench/pong_cases.txt
// p1_up p1_down p2_up p2_down frames p1_score p2_score, all hex
// scores are the expected values after the frames of that line
1 0 1 0 5a 0 0
1 0 0 0 28 0 0
0 0 0 1 fa 0 0
1 1 0 0 14 0 0
0 0 0 0 12c 1 0

// File: testbench/pong_tb.sv
`timescale 1ns/1ps

`include "pong_defines.svh"

module pong_tb import pong_pkg::*; ();

	localparam int NUM_LINES = 5;
	localparam int WAIT_LIMIT = 200;

	logic    clock;
	logic    reset_n;
	logic    go, p1_up, p1_down, p2_up, p2_down;
	logic    write_en;
	coord_t  x, y;
	colour_t colour;
	score_t  p1_score, p2_score;

	// values picked up by the input driver after each edge
	logic cur_go, cur_p1_up, cur_p1_down, cur_p2_up, cur_p2_down;

	logic [15:0] cases [0:NUM_LINES*7-1];

	// reference model state
	int m_p1y, m_p2y, m_bx, m_by, m_s1, m_s2;
	bit m_right, m_up;

	pong_top DUT (
		.clock(clock), .reset_n(reset_n), .go(go),
		.p1_up(p1_up), .p1_down(p1_down), .p2_up(p2_up), .p2_down(p2_down),
		.write_en(write_en), .x(x), .y(y), .colour(colour),
		.p1_score(p1_score), .p2_score(p2_score)
	);

	initial begin
		clock = 1'b0;
		forever #4 clock = ~clock;
	end

	initial begin
		forever begin
			@(posedge clock);
			#1;
			go = cur_go;
			p1_up = cur_p1_up;
			p1_down = cur_p1_down;
			p2_up = cur_p2_up;
			p2_down = cur_p2_down;
		end
	end

	task automatic stop_on_error(input string msg);
		$display("%s at %0t", msg, $time);
		$display("=== FAIL ===");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_coord(input string name, input coord_t got, input coord_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			stop_on_error("coordinate check failed");
		end
	endtask

	task automatic check_colour(input string name, input colour_t got, input colour_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			stop_on_error("colour check failed");
		end
	endtask

	task automatic check_score(input string name, input score_t got, input score_t exp);
		if (got !== exp) begin
			$display("MISMATCH time=%0t %s got=%0d expected=%0d", $time, name, got, exp);
			stop_on_error("score check failed");
		end
	endtask

	// next negedge with write_en high
	task automatic wait_write();
		int n;
		n = 0;
		@(negedge clock);
		while (write_en !== 1'b1) begin
			n++;
			if (n > WAIT_LIMIT)
				stop_on_error("timed out waiting for a frame-buffer write");
			@(negedge clock);
		end
	endtask

	// pixels come row by row with x fastest
	task automatic check_pass(input colour_t col, input int x0, input int y0,
			input int w, input int h);
		for (int i = 0; i < w * h; i++) begin
			wait_write();
			check_coord("x", x, coord_t'(x0 + i % w));
			check_coord("y", y, coord_t'(y0 + i / w));
			check_colour("colour", colour, col);
		end
	endtask

	function automatic int move_paddle(input int py, input bit up, input bit down);
		if (down && py <= `PADDLE_Y_MAX)
			return py + 1;
		else if (up && py >= `PADDLE_Y_MIN)
			return py - 1;
		return py;
	endfunction

	task automatic model_update(input bit u1, input bit d1, input bit u2, input bit d2);
		bit nr, nu, in_goal, lg, rg;
		nr = m_right;
		nu = m_up;
		if (m_bx == `WALL_LEFT)
			nr = 1;
		else if (m_bx == `WALL_RIGHT)
			nr = 0;
		if (m_by == `WALL_TOP)
			nu = 0;
		else if (m_by == `WALL_BOTTOM)
			nu = 1;
		if (m_p1y <= m_by && m_by <= m_p1y + `PADDLE_H) begin
			if (m_bx + `BALL_SIZE == `P1_X)
				nr = 0;
			else if (m_bx == `P1_X + `PADDLE_W)
				nr = 1;
		end
		if (m_p2y <= m_by && m_by <= m_p2y + `PADDLE_H) begin
			if (m_bx + `BALL_SIZE == `P2_X)
				nr = 0;
			else if (m_bx == `P2_X + `PADDLE_W)
				nr = 1;
		end
		in_goal = (m_by >= `GOAL_Y_LO) && (m_by <= `GOAL_Y_HI);
		lg = (m_bx == `WALL_LEFT) && in_goal;
		rg = (m_bx + `BALL_SIZE == `RIGHT_GOAL_EDGE) && in_goal;
		m_bx = m_right ? m_bx + 1 : m_bx - 1;
		m_by = m_up ? m_by - 1 : m_by + 1;
		m_right = nr;
		m_up = nu;
		m_p1y = move_paddle(m_p1y, u1, d1);
		m_p2y = move_paddle(m_p2y, u2, d2);
		if (lg || rg) begin
			if (lg)
				m_s2 = (m_s2 + 1) % 16;
			else
				m_s1 = (m_s1 + 1) % 16;
			m_bx = lg ? `SPAWN_RIGHT_X : `SPAWN_LEFT_X;
			m_by = `SPAWN_Y;
			m_right = 1;
			m_up = 1;
		end
	endtask

	task automatic run_frame(input bit u1, input bit d1, input bit u2, input bit d2);
		cur_p1_up = u1;
		cur_p1_down = d1;
		cur_p2_up = u2;
		cur_p2_down = d2;
		check_pass(`COLOUR_P1, `P1_X, m_p1y, `PADDLE_W, `PADDLE_H);
		check_pass(`COLOUR_P2, `P2_X, m_p2y, `PADDLE_W, `PADDLE_H);
		check_pass(`COLOUR_BALL, m_bx, m_by, `BALL_SIZE, `BALL_SIZE);
		check_pass(`COLOUR_BLACK, `P1_X, m_p1y, `PADDLE_W, `PADDLE_H);
		check_pass(`COLOUR_BLACK, `P2_X, m_p2y, `PADDLE_W, `PADDLE_H);
		check_pass(`COLOUR_BLACK, m_bx, m_by, `BALL_SIZE, `BALL_SIZE);
		model_update(u1, d1, u2, d2);
		// scores settle two cycles after the last erase pixel
		repeat (2) @(negedge clock);
		check_score("p1_score", p1_score, score_t'(m_s1));
		check_score("p2_score", p2_score, score_t'(m_s2));
	endtask

	initial begin
		reset_n = 1'b1;
		go = 1'b0;
		p1_up = 1'b0;
		p1_down = 1'b0;
		p2_up = 1'b0;
		p2_down = 1'b0;
		cur_go = 1'b0;
		cur_p1_up = 1'b0;
		cur_p1_down = 1'b0;
		cur_p2_up = 1'b0;
		cur_p2_down = 1'b0;
		$readmemh("testbench/pong_cases.txt", cases);
		repeat (8) @(posedge clock);
		#1;
		reset_n = 1'b0;

		// idle while go is low
		repeat (20) begin
			@(negedge clock);
			if (write_en !== 1'b0)
				stop_on_error("write_en went high while go was low");
			check_score("p1_score", p1_score, '0);
			check_score("p2_score", p2_score, '0);
		end

		m_p1y = `PADDLE_Y0;
		m_p2y = `PADDLE_Y0;
		m_bx = `BALL_X0;
		m_by = `BALL_Y0;
		m_right = 1;
		m_up = 1;
		m_s1 = 0;
		m_s2 = 0;
		cur_go = 1'b1;

		for (int l = 0; l < NUM_LINES; l++) begin
			for (int f = 0; f < int'(cases[l*7+4]); f++)
				run_frame(cases[l*7][0], cases[l*7+1][0], cases[l*7+2][0], cases[l*7+3][0]);
			check_score("p1_score", p1_score, score_t'(cases[l*7+5]));
			check_score("p2_score", p2_score, score_t'(cases[l*7+6]));
		end

		$display("=== PASS ===");
		$finish;
	end

endmodule
